// File: src/core_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared constants for the radio control core: settings bus widths,
// register addresses, compat numbers, PPS and readback select codes
//////////////////////////////////////////////////////////////////////

package core_pkg;

    // settings bus
    localparam int SET_ADDR_W = 8;
    localparam int SET_DATA_W = 32;

    // register widths
    localparam int RB_SEL_W   = 2;
    localparam int PPS_SEL_W  = 2;
    localparam int GPSDO_ST_W = 8;

    //////////////////////////////////////////////////////////////////////
    // setting addresses
    //////////////////////////////////////////////////////////////////////
    localparam logic [SET_ADDR_W-1:0] SR_CORE_MISC     = 8'd16;
    localparam logic [SET_ADDR_W-1:0] SR_CORE_READBACK = 8'd32;
    localparam logic [SET_ADDR_W-1:0] SR_CORE_GPSDO_ST = 8'd40;
    localparam logic [SET_ADDR_W-1:0] SR_CORE_SYNC     = 8'd48;

    // compatibility word, major in the upper half
    localparam logic [15:0] COMPAT_MAJOR = 16'h000E;
    localparam logic [15:0] COMPAT_MINOR = 16'h0000;

    // single radio build
    localparam logic [7:0] RADIO_STATUS = 8'h01;

    //////////////////////////////////////////////////////////////////////
    // select codes
    //////////////////////////////////////////////////////////////////////
    // pps source, code 3 selects nothing
    localparam logic [PPS_SEL_W-1:0] PPS_SEL_GPSDO = 2'd0;
    localparam logic [PPS_SEL_W-1:0] PPS_SEL_EXT   = 2'd1;
    localparam logic [PPS_SEL_W-1:0] PPS_SEL_INT   = 2'd2;

    // readback word
    localparam logic [RB_SEL_W-1:0] RB_SEL_COMPAT  = 2'd0;
    localparam logic [RB_SEL_W-1:0] RB_SEL_MISC_IN = 2'd1;
    localparam logic [RB_SEL_W-1:0] RB_SEL_STATUS  = 2'd2;
    localparam logic [RB_SEL_W-1:0] RB_SEL_LOCK    = 2'd3;

endpackage

// File: src/wb_settings_slave.sv
//////////////////////////////////////////////////////////////////////
// wishbone classic slave turning bus cycles into settings strobes
// and returning the current readback word
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module wb_settings_slave
    import core_pkg::*;
(
    input  logic                  i_radio_clk,
    input  logic                  i_bus_rst,

    // wishbone slave side
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_we,
    input  logic [SET_ADDR_W-1:0] i_wb_adr,
    input  logic [SET_DATA_W-1:0] i_wb_dat,
    output logic                  o_wb_ack,
    output logic [SET_DATA_W-1:0] o_wb_dat,

    // readback word from the mux
    input  logic [SET_DATA_W-1:0] i_rb_data,

    // settings bus
    output logic                  o_set_stb,
    output logic [SET_ADDR_W-1:0] o_set_addr,
    output logic [SET_DATA_W-1:0] o_set_data
);

    logic wb_req;
    logic wb_wr_req;
    logic wb_rd_req;

    // new request only while ack is low, so each cycle is acked once
    assign wb_req    = i_wb_cyc & i_wb_stb & ~o_wb_ack;
    assign wb_wr_req = wb_req & i_wb_we;
    assign wb_rd_req = wb_req & ~i_wb_we;

    //////////////////////////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            o_wb_ack  <= 1'b0;
            o_set_stb <= 1'b0;
        end else begin
            o_wb_ack  <= wb_req;
            // strobe lines up with the write ack
            o_set_stb <= wb_wr_req;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // data capture
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_radio_clk) begin
        if (wb_wr_req) begin
            o_set_addr <= i_wb_adr;
            o_set_data <= i_wb_dat;
        end
        // read address is ignored, the select register picks the word
        if (wb_rd_req) begin
            o_wb_dat <= i_rb_data;
        end
    end

endmodule

// File: src/core_settings_regs.sv
//////////////////////////////////////////////////////////////////////
// core settings registers: misc outputs, readback select,
// gpsdo status and the pps / time sync register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module core_settings_regs
    import core_pkg::*;
(
    input  logic                  i_radio_clk,
    input  logic                  i_bus_rst,

    // settings bus
    input  logic                  i_set_stb,
    input  logic [SET_ADDR_W-1:0] i_set_addr,
    input  logic [SET_DATA_W-1:0] i_set_data,

    // register outputs
    output logic [SET_DATA_W-1:0] o_misc_outs,
    output logic [RB_SEL_W-1:0]   o_rb_sel,
    output logic [GPSDO_ST_W-1:0] o_gpsdo_st,
    output logic [PPS_SEL_W-1:0]  o_pps_sel,
    output logic                  o_time_sync
);

    logic hit_misc;
    logic hit_rb_sel;
    logic hit_gpsdo_st;
    logic hit_sync;

    // address decode, unknown addresses hit nothing
    assign hit_misc     = i_set_stb && (i_set_addr == SR_CORE_MISC);
    assign hit_rb_sel   = i_set_stb && (i_set_addr == SR_CORE_READBACK);
    assign hit_gpsdo_st = i_set_stb && (i_set_addr == SR_CORE_GPSDO_ST);
    assign hit_sync     = i_set_stb && (i_set_addr == SR_CORE_SYNC);

    //////////////////////////////////////////////////////////////////////
    // control registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            o_misc_outs <= '0;
            o_rb_sel    <= RB_SEL_COMPAT;
            o_pps_sel   <= PPS_SEL_GPSDO;
            o_time_sync <= 1'b0;
        end else begin
            if (hit_misc) begin
                o_misc_outs <= i_set_data;
            end
            if (hit_rb_sel) begin
                o_rb_sel <= i_set_data[RB_SEL_W-1:0];
            end
            // sync word: pps select low, time sync just above it
            if (hit_sync) begin
                o_pps_sel   <= i_set_data[PPS_SEL_W-1:0];
                o_time_sync <= i_set_data[PPS_SEL_W];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // gpsdo status
    //////////////////////////////////////////////////////////////////////
    // host keeps its gpsdo view across a core reset
    always_ff @(posedge i_radio_clk) begin
        if (hit_gpsdo_st) begin
            o_gpsdo_st <= i_set_data[GPSDO_ST_W-1:0];
        end
    end

endmodule

// File: src/pps_generator.sv
//////////////////////////////////////////////////////////////////////
// internal pps source, quarter duty pulse once per second
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pps_generator #(
    parameter int PPS_CLK_FREQ = 100000000
) (
    input  logic i_radio_clk,
    input  logic i_bus_rst,
    output logic o_pps_int
);

    localparam int CNT_W = (PPS_CLK_FREQ > 1) ? $clog2(PPS_CLK_FREQ) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PPS_CLK_FREQ - 1);
    localparam logic [CNT_W-1:0] CNT_HIGH = CNT_W'(PPS_CLK_FREQ / 4);

    logic [CNT_W-1:0] cycle_cnt;

    // wrapping cycle counter, one wrap per second
    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            cycle_cnt <= '0;
        end else if (cycle_cnt == CNT_LAST) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + CNT_W'(1);
        end
    end

    // registered so the pulse leaves glitch free
    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            o_pps_int <= 1'b0;
        end else begin
            o_pps_int <= (cycle_cnt < CNT_HIGH);
        end
    end

endmodule

// File: src/pps_select.sv
//////////////////////////////////////////////////////////////////////
// pps input synchronisers and source select
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pps_select
    import core_pkg::*;
(
    input  logic                 i_radio_clk,
    input  logic                 i_bus_rst,

    // pps sources
    input  logic                 i_pps_gps,
    input  logic                 i_pps_ext,
    input  logic                 i_pps_int,

    input  logic [PPS_SEL_W-1:0] i_pps_sel,
    output logic                 o_pps
);

    logic [1:0] gps_pps_sync;
    logic [1:0] ext_pps_sync;
    logic [1:0] int_pps_sync;

    // two flops per source into radio_clk
    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            gps_pps_sync <= 2'b00;
            ext_pps_sync <= 2'b00;
            int_pps_sync <= 2'b00;
        end else begin
            gps_pps_sync <= {gps_pps_sync[0], i_pps_gps};
            ext_pps_sync <= {ext_pps_sync[0], i_pps_ext};
            int_pps_sync <= {int_pps_sync[0], i_pps_int};
        end
    end

    // source mux, unused code gives no pps
    always_comb begin
        case (i_pps_sel)
            PPS_SEL_GPSDO: o_pps = gps_pps_sync[1];
            PPS_SEL_EXT:   o_pps = ext_pps_sync[1];
            PPS_SEL_INT:   o_pps = int_pps_sync[1];
            default:       o_pps = 1'b0;
        endcase
    end

endmodule

// File: src/core_readback.sv
//////////////////////////////////////////////////////////////////////
// front-end lock synchroniser and readback word select
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module core_readback
    import core_pkg::*;
(
    input  logic                  i_radio_clk,
    input  logic                  i_bus_rst,

    input  logic [RB_SEL_W-1:0]   i_rb_sel,
    input  logic [SET_DATA_W-1:0] i_rb_misc,
    input  logic [GPSDO_ST_W-1:0] i_gpsdo_st,
    input  logic [1:0]            i_lock_signals,

    output logic [SET_DATA_W-1:0] o_rb_data
);

    logic [1:0] lock_meta;
    logic [1:0] lock_state;

    // lock inputs come from the front-end, not from radio_clk
    always_ff @(posedge i_radio_clk) begin
        if (i_bus_rst) begin
            lock_meta  <= 2'b00;
            lock_state <= 2'b00;
        end else begin
            lock_meta  <= i_lock_signals;
            lock_state <= lock_meta;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // readback mux
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (i_rb_sel)
            RB_SEL_COMPAT:  o_rb_data = {COMPAT_MAJOR, COMPAT_MINOR};
            RB_SEL_MISC_IN: o_rb_data = i_rb_misc;
            RB_SEL_STATUS:  o_rb_data = {16'h0000, RADIO_STATUS, i_gpsdo_st};
            RB_SEL_LOCK:    o_rb_data = {30'h0, lock_state};
            default:        o_rb_data = '0;
        endcase
    end

endmodule

// File: src/core_ctrl_top.sv
//////////////////////////////////////////////////////////////////////
// radio control core top: wishbone slave, settings registers,
// pps generation and select, readback mux
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module core_ctrl_top
    import core_pkg::*;
#(
    parameter int PPS_CLK_FREQ = 100000000
) (
    input  logic                  i_radio_clk,
    input  logic                  i_bus_rst,

    // wishbone
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_we,
    input  logic [SET_ADDR_W-1:0] i_wb_adr,
    input  logic [SET_DATA_W-1:0] i_wb_dat,
    output logic                  o_wb_ack,
    output logic [SET_DATA_W-1:0] o_wb_dat,

    // pps and board status
    input  logic                  i_pps_gps,
    input  logic                  i_pps_ext,
    input  logic [SET_DATA_W-1:0] i_rb_misc,
    input  logic [1:0]            i_lock_signals,

    output logic [SET_DATA_W-1:0] o_misc_outs,
    output logic                  o_time_sync,
    output logic                  o_pps
);

    logic                  set_stb;
    logic [SET_ADDR_W-1:0] set_addr;
    logic [SET_DATA_W-1:0] set_data;
    logic [SET_DATA_W-1:0] rb_data;
    logic [RB_SEL_W-1:0]   rb_sel;
    logic [GPSDO_ST_W-1:0] gpsdo_st;
    logic [PPS_SEL_W-1:0]  pps_sel;
    logic                  pps_int;

    //////////////////////////////////////////////////////////////////////
    // bus and settings
    //////////////////////////////////////////////////////////////////////
    wb_settings_slave u_wb_settings_slave (
        .i_radio_clk (i_radio_clk),
        .i_bus_rst   (i_bus_rst),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_we     (i_wb_we),
        .i_wb_adr    (i_wb_adr),
        .i_wb_dat    (i_wb_dat),
        .o_wb_ack    (o_wb_ack),
        .o_wb_dat    (o_wb_dat),
        .i_rb_data   (rb_data),
        .o_set_stb   (set_stb),
        .o_set_addr  (set_addr),
        .o_set_data  (set_data)
    );

    core_settings_regs u_core_settings_regs (
        .i_radio_clk (i_radio_clk),
        .i_bus_rst   (i_bus_rst),
        .i_set_stb   (set_stb),
        .i_set_addr  (set_addr),
        .i_set_data  (set_data),
        .o_misc_outs (o_misc_outs),
        .o_rb_sel    (rb_sel),
        .o_gpsdo_st  (gpsdo_st),
        .o_pps_sel   (pps_sel),
        .o_time_sync (o_time_sync)
    );

    //////////////////////////////////////////////////////////////////////
    // pps and readback
    //////////////////////////////////////////////////////////////////////
    pps_generator #(
        .PPS_CLK_FREQ (PPS_CLK_FREQ)
    ) u_pps_generator (
        .i_radio_clk (i_radio_clk),
        .i_bus_rst   (i_bus_rst),
        .o_pps_int   (pps_int)
    );

    pps_select u_pps_select (
        .i_radio_clk (i_radio_clk),
        .i_bus_rst   (i_bus_rst),
        .i_pps_gps   (i_pps_gps),
        .i_pps_ext   (i_pps_ext),
        .i_pps_int   (pps_int),
        .i_pps_sel   (pps_sel),
        .o_pps       (o_pps)
    );

    core_readback u_core_readback (
        .i_radio_clk    (i_radio_clk),
        .i_bus_rst      (i_bus_rst),
        .i_rb_sel       (rb_sel),
        .i_rb_misc      (i_rb_misc),
        .i_gpsdo_st     (gpsdo_st),
        .i_lock_signals (i_lock_signals),
        .o_rb_data      (rb_data)
    );

endmodule

// File: tests/tb_clock_gen.sv
//////////////////////////////////////////////////////////////////////
// testbench clock (40 ns) and 16-cycle bus reset, re-armed on request
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_clock_gen (
    input  logic i_rst_req,
    output logic o_radio_clk,
    output logic o_bus_rst
);

    logic [3:0] rst_cnt;

    initial begin
        o_radio_clk = 1'b0;
        forever #20 o_radio_clk = ~o_radio_clk;
    end

    initial begin
        o_bus_rst = 1'b1;
        rst_cnt   = 4'd0;
    end

    // reset drops on the 16th edge
    always @(posedge o_radio_clk) begin
        if (i_rst_req) begin
            o_bus_rst <= 1'b1;
            rst_cnt   <= 4'd0;
        end else if (o_bus_rst) begin
            if (rst_cnt == 4'd15) begin
                o_bus_rst <= 1'b0;
            end else begin
                rst_cnt <= rst_cnt + 4'd1;
            end
        end
    end

endmodule

// File: tests/core_ctrl_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the radio control core: table of bus steps,
// pps source checks and gpsdo status across reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module core_ctrl_tb
    import core_pkg::*;
();

    localparam int ACK_TIMEOUT = 8;
    localparam int RST_TIMEOUT = 64;
    localparam logic [31:0] EXP_COMPAT = {16'd14, 16'd0};
    localparam logic [7:0]  SR_UNUSED  = 8'd99;
    localparam logic [31:0] ALL        = 32'hffff_ffff;

    // table operations
    localparam logic [1:0] OP_WRITE = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_MISC  = 2'd2;
    localparam logic [1:0] OP_TSYNC = 2'd3;

    typedef struct packed {
        logic [1:0]  op;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic [31:0] mask;
    } step_t;

    logic        radio_clk, bus_rst, rst_req;
    logic        wb_cyc, wb_stb, wb_we, wb_ack;
    logic [7:0]  wb_adr;
    logic [31:0] wb_dat, wb_rdat;
    logic        pps_gps, pps_ext, time_sync, pps;
    logic [31:0] rb_misc, misc_outs;
    logic [1:0]  lock_signals;

    step_t       steps[$];
    int          seg_end;
    int          highs;
    logic [31:0] misc_word, other_word, rb_misc_word, gpsdo_word;

    tb_clock_gen u_tb_clock_gen (
        .i_rst_req   (rst_req),
        .o_radio_clk (radio_clk),
        .o_bus_rst   (bus_rst)
    );

    core_ctrl_top #(
        .PPS_CLK_FREQ (64)
    ) u_core_ctrl_top (
        .i_radio_clk    (radio_clk),
        .i_bus_rst      (bus_rst),
        .i_wb_cyc       (wb_cyc),
        .i_wb_stb       (wb_stb),
        .i_wb_we        (wb_we),
        .i_wb_adr       (wb_adr),
        .i_wb_dat       (wb_dat),
        .o_wb_ack       (wb_ack),
        .o_wb_dat       (wb_rdat),
        .i_pps_gps      (pps_gps),
        .i_pps_ext      (pps_ext),
        .i_rb_misc      (rb_misc),
        .i_lock_signals (lock_signals),
        .o_misc_outs    (misc_outs),
        .o_time_sync    (time_sync),
        .o_pps          (pps)
    );

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h",
                                     name, got, exp));
        end
    endtask

    function automatic void add_step(input logic [1:0] op, input logic [7:0] addr,
                                     input logic [31:0] data, input logic [31:0] exp,
                                     input logic [31:0] mask);
        step_t s;
        s = '{op, addr, data, exp, mask};
        steps.push_back(s);
    endfunction

    // one classic cycle, ack must come after exactly one edge and last one cycle
    task automatic bus_access(input logic we, input logic [7:0] adr,
                              input logic [31:0] dat, output logic [31:0] rdata);
        int cycles;
        cycles = 0;
        @(posedge radio_clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= we;
        wb_adr <= adr;
        wb_dat <= dat;
        do begin
            @(posedge radio_clk);
            #1;
            cycles++;
            if (cycles > ACK_TIMEOUT) begin
                report_failure("bus slave gave no ack within the timeout");
            end
        end while (wb_ack !== 1'b1);
        check_value("ack latency", 32'(cycles), 32'd1);
        rdata = wb_rdat;
        @(posedge radio_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        #1;
        check_value("o_wb_ack", {31'd0, wb_ack}, 32'd0);
    endtask

    task automatic run_steps(input int first, input int last);
        logic [31:0] rdata;
        int i;
        for (i = first; i <= last; i++) begin
            case (steps[i].op)
                OP_WRITE: bus_access(1'b1, steps[i].addr, steps[i].data, rdata);
                OP_READ: begin
                    bus_access(1'b0, steps[i].addr, 32'd0, rdata);
                    check_value("o_wb_dat", rdata & steps[i].mask, steps[i].exp & steps[i].mask);
                end
                OP_MISC: check_value("o_misc_outs", misc_outs, steps[i].exp);
                default: check_value("o_time_sync", {31'd0, time_sync}, steps[i].exp);
            endcase
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (bus_rst !== 1'b0) begin
            @(posedge radio_clk);
            #1;
            cycles++;
            if (cycles > RST_TIMEOUT) begin
                report_failure("bus reset was never released");
            end
        end
    endtask

    // one-cycle pulse on the gps or ext input, seen on o_pps two edges later
    task automatic check_pps_pulse(input logic use_gps);
        int k;
        @(posedge radio_clk);
        if (use_gps) begin
            pps_gps <= 1'b1;
        end else begin
            pps_ext <= 1'b1;
        end
        for (k = 0; k < 6; k++) begin
            #1;
            check_value("o_pps", {31'd0, pps}, (k == 2) ? 32'd1 : 32'd0);
            @(posedge radio_clk);
            pps_gps <= 1'b0;
            pps_ext <= 1'b0;
        end
    endtask

    task automatic count_pps_high(input int cycles, output int n_high);
        int n;
        n_high = 0;
        for (n = 0; n < cycles; n++) begin
            @(posedge radio_clk);
            #1;
            if (pps === 1'b1) n_high++;
        end
    endtask

    initial begin
        void'($urandom(32'h00ef_e107));
        rst_req      = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = 8'd0;
        wb_dat       = 32'd0;
        pps_gps      = 1'b0;
        pps_ext      = 1'b0;
        rb_misc      = 32'd0;
        lock_signals = 2'b00;
        misc_word    = $urandom();
        other_word   = $urandom();
        rb_misc_word = $urandom();
        gpsdo_word   = $urandom();

        ////////////////////////////////////////////////////////////////////
        // after first reset: registers, unknown address, readback words
        ////////////////////////////////////////////////////////////////////
        add_step(OP_MISC, 8'd0, 32'd0, 32'd0, ALL);
        add_step(OP_TSYNC, 8'd0, 32'd0, 32'd0, ALL);
        add_step(OP_READ, 8'd0, 32'd0, EXP_COMPAT, ALL);
        add_step(OP_WRITE, SR_CORE_MISC, misc_word, 32'd0, ALL);
        add_step(OP_MISC, 8'd0, 32'd0, misc_word, ALL);
        add_step(OP_WRITE, SR_UNUSED, other_word, 32'd0, ALL);
        add_step(OP_MISC, 8'd0, 32'd0, misc_word, ALL);
        add_step(OP_TSYNC, 8'd0, 32'd0, 32'd0, ALL);
        add_step(OP_READ, SR_UNUSED, 32'd0, EXP_COMPAT, ALL);
        add_step(OP_WRITE, SR_CORE_READBACK, 32'd1, 32'd0, ALL);
        add_step(OP_READ, 8'd0, 32'd0, rb_misc_word, ALL);
        add_step(OP_WRITE, SR_CORE_READBACK, 32'd3, 32'd0, ALL);
        add_step(OP_READ, 8'd0, 32'd0, 32'h0000_0002, 32'h0000_0003);
        add_step(OP_WRITE, SR_CORE_GPSDO_ST, gpsdo_word, 32'd0, ALL);
        add_step(OP_WRITE, SR_CORE_READBACK, 32'd2, 32'd0, ALL);
        add_step(OP_READ, 8'd0, 32'd0, {16'd0, 8'd1, gpsdo_word[7:0]}, ALL);
        // ext pps with the time sync bit set
        add_step(OP_WRITE, SR_CORE_SYNC, 32'h0000_0005, 32'd0, ALL);
        add_step(OP_TSYNC, 8'd0, 32'd0, 32'd1, ALL);
        seg_end = steps.size();
        // after second reset, gpsdo byte survives
        add_step(OP_MISC, 8'd0, 32'd0, 32'd0, ALL);
        add_step(OP_TSYNC, 8'd0, 32'd0, 32'd0, ALL);
        add_step(OP_READ, 8'd0, 32'd0, EXP_COMPAT, ALL);
        add_step(OP_WRITE, SR_CORE_READBACK, 32'd2, 32'd0, ALL);
        add_step(OP_READ, 8'd0, 32'd0, {16'd0, 8'd1, gpsdo_word[7:0]}, ALL);

        wait_reset_release();
        @(posedge radio_clk);
        rb_misc      <= rb_misc_word;
        lock_signals <= 2'b10;
        run_steps(0, seg_end - 1);
        check_pps_pulse(1'b0);

        ////////////////////////////////////////////////////////////////////
        // internal pps, then the unused select code
        ////////////////////////////////////////////////////////////////////
        bus_access(1'b1, SR_CORE_SYNC, 32'h0000_0002, misc_word);
        check_value("o_time_sync", {31'd0, time_sync}, 32'd0);
        count_pps_high(192, highs);
        check_value("o_pps high cycles", 32'(highs), 32'd48);
        // code 3 with time sync set, so the next reset has to clear it
        bus_access(1'b1, SR_CORE_SYNC, 32'h0000_0007, misc_word);
        check_value("o_time_sync", {31'd0, time_sync}, 32'd1);
        @(posedge radio_clk);
        pps_ext <= 1'b1;
        @(posedge radio_clk);
        pps_ext <= 1'b0;
        count_pps_high(128, highs);
        check_value("o_pps high cycles", 32'(highs), 32'd0);

        @(posedge radio_clk);
        rst_req <= 1'b1;
        @(posedge radio_clk);
        rst_req <= 1'b0;
        #1;
        wait_reset_release();
        run_steps(seg_end, steps.size() - 1);
        // pps select back on the gpsdo source after reset
        check_pps_pulse(1'b1);

        $display("All tests passed");
        $finish;
    end

endmodule

// File: src.f
src/core_pkg.sv
src/wb_settings_slave.sv
src/core_settings_regs.sv
src/pps_generator.sv
src/pps_select.sv
src/core_readback.sv
src/core_ctrl_top.sv
tests/tb_clock_gen.sv
tests/core_ctrl_tb.sv

// File: Makefile
.PHONY: simulate clean

simulate:
	verilator --binary --timing -f src.f --top-module core_ctrl_tb -Mdir obj_dir -o core_ctrl_sim
	./obj_dir/core_ctrl_sim

clean:
	rm -rf obj_dir
